/* hw/spim_pkg.sv */
/*
 * spim_pkg
 * shared types for the multi-lane SPI master: data word, burst length,
 * slave select index and the lane burst state machine encoding
 */

`default_nettype none

package spim_pkg;

	// one SPI data word, shifted MSB first
	typedef logic [31:0] word_t;

	// burst length field, a burst moves value + 1 words
	typedef logic [13:0] brstlen_t;

	// slave select index inside one lane
	typedef logic [1:0] ssel_t;

	// lane burst engine states
	typedef enum logic [2:0] {
		IDLE,   // waiting for a command
		LOAD,   // first word fetched
		SHIFT,  // words with more to follow
		LAST,   // final word of the burst
		END     // burst closed, done pulse
	} lane_st_e;

endpackage

`default_nettype wire

/* hw/spim_lane_if.sv */
/*
 * spim_lane_if
 * per-lane link between the dispatcher, one burst engine and the collector
 */

`default_nettype none

interface spim_lane_if;

	logic               cmd_valid;    // one-cycle command pulse
	logic               cmd_rdnwr;    // 1 = read, 0 = write
	spim_pkg::ssel_t    cmd_ssel;
	spim_pkg::brstlen_t cmd_brstlen;

	logic               done;         // lane leaves END
	logic               tx_req;       // fetch next write word
	spim_pkg::word_t    tx_data;      // head of tx buffer, zero when empty

	logic               rx_valid;     // full word received on a read
	spim_pkg::word_t    rx_data;

	modport disp (
		output cmd_valid, cmd_rdnwr, cmd_ssel, cmd_brstlen, tx_data,
		input  done, tx_req
	);

	modport lane (
		input  cmd_valid, cmd_rdnwr, cmd_ssel, cmd_brstlen, tx_data,
		output done, tx_req, rx_valid, rx_data
	);

	modport coll (
		input rx_valid, rx_data
	);

endinterface

`default_nettype wire

/* hw/spim_dispatch.sv */
/*
 * spim_dispatch
 * routes credited commands to their lane and keeps one transmit FIFO per lane,
 * turning lane completion and FIFO pops into credit pulses
 */

`default_nettype none

module spim_dispatch #(
	parameter  int NUM_LANES = 2,
	parameter  int TX_DEPTH  = 2,
	localparam int LANE_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                     sclk_in,
	input  logic                     rst_n,
	input  logic                     cmd_valid,
	input  logic                     cmd_rdnwr,
	input  logic [LANE_W-1:0]        cmd_lane,
	input  spim_pkg::ssel_t          cmd_ssel,
	input  spim_pkg::brstlen_t       cmd_brstlen,
	input  logic                     tx_valid,
	input  logic [LANE_W-1:0]        tx_lane,
	input  spim_pkg::word_t          tx_data,
	output logic [NUM_LANES-1:0]     cmd_credit,
	output logic [NUM_LANES-1:0]     tx_credit,
	spim_lane_if.disp                lanes [NUM_LANES]
);

	localparam int PTR_W = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
	localparam int CNT_W = $clog2(TX_DEPTH + 1);

	logic               cmd_rdnwr_q;
	spim_pkg::ssel_t    cmd_ssel_q;
	spim_pkg::brstlen_t cmd_brstlen_q;

	// command fields, shared by all lanes, qualified by each lane's cmd_valid
	always_ff @(posedge sclk_in) begin
		if (cmd_valid) begin
			cmd_rdnwr_q   <= cmd_rdnwr;
			cmd_ssel_q    <= cmd_ssel;
			cmd_brstlen_q <= cmd_brstlen;
		end
	end

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		spim_pkg::word_t  mem [TX_DEPTH];
		logic [PTR_W-1:0] wr_ptr;
		logic [PTR_W-1:0] rd_ptr;
		logic [CNT_W-1:0] fill;
		logic             push;
		logic             pop;
		logic             cmd_credit_q;
		logic             tx_credit_q;

		assign push = tx_valid && (tx_lane == LANE_W'(g));
		assign pop  = lanes[g].tx_req && (fill != '0);  // underrun pops nothing

		assign lanes[g].tx_data     = (fill != '0) ? mem[rd_ptr] : '0;
		assign lanes[g].cmd_rdnwr   = cmd_rdnwr_q;
		assign lanes[g].cmd_ssel    = cmd_ssel_q;
		assign lanes[g].cmd_brstlen = cmd_brstlen_q;

		assign cmd_credit[g] = cmd_credit_q;
		assign tx_credit[g]  = tx_credit_q;

		always_ff @(posedge sclk_in or negedge rst_n) begin
			if (!rst_n) begin
				lanes[g].cmd_valid <= 1'b0;
				wr_ptr             <= '0;
				rd_ptr             <= '0;
				fill               <= '0;
				cmd_credit_q       <= 1'b0;
				tx_credit_q        <= 1'b0;
			end else begin
				lanes[g].cmd_valid <= cmd_valid && (cmd_lane == LANE_W'(g));
				cmd_credit_q       <= lanes[g].done;  // credit back the cycle after done
				tx_credit_q        <= pop;
				if (push)
					wr_ptr <= (wr_ptr == PTR_W'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= (rd_ptr == PTR_W'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				case ({push, pop})
					2'b10:   fill <= fill + 1'b1;
					2'b01:   fill <= fill - 1'b1;
					default: fill <= fill;
				endcase
			end
		end

		always_ff @(posedge sclk_in) begin
			if (push)
				mem[wr_ptr] <= tx_data;
		end
	end

endmodule

`default_nettype wire

/* hw/spim_lane.sv */
/*
 * spim_lane
 * mode 0 SPI burst engine for one lane: latches a command, drives one of four
 * slave selects and shifts brstlen + 1 words of 32 bits, MSB first
 */

`default_nettype none

module spim_lane (
	input  logic       sclk_in,
	input  logic       rst_n,
	output logic [3:0] ss_n,
	output logic       mosi,
	input  logic       miso,
	spim_lane_if.lane  bus
);

	spim_pkg::lane_st_e state;
	spim_pkg::lane_st_e state_nxt;
	logic               rdnwr_q;
	spim_pkg::ssel_t    ssel_q;
	spim_pkg::brstlen_t word_cnt;      // words left after the current one
	logic [4:0]         rx_cnt;        // bit index, rising edge side
	logic [4:0]         tx_cnt;        // bit index, falling edge side
	spim_pkg::word_t    rx_shift;
	spim_pkg::word_t    tx_hold;       // next word to transmit
	spim_pkg::word_t    tx_shift;
	spim_pkg::word_t    tx_load_word;
	logic               shifting;
	logic               word_end;

	assign shifting     = (state == spim_pkg::SHIFT) || (state == spim_pkg::LAST);
	assign word_end     = shifting && (rx_cnt == 5'd31);
	assign tx_load_word = rdnwr_q ? '0 : tx_hold;  // reads send zeros

	////////////////////
	// burst state machine
	////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			spim_pkg::IDLE: begin
				if (bus.cmd_valid)
					state_nxt = spim_pkg::LOAD;
			end
			spim_pkg::LOAD: begin
				state_nxt = (word_cnt == '0) ? spim_pkg::LAST : spim_pkg::SHIFT;
			end
			spim_pkg::SHIFT: begin
				if (word_end && (word_cnt == 'd1))
					state_nxt = spim_pkg::LAST;
			end
			spim_pkg::LAST: begin
				if (word_end)
					state_nxt = spim_pkg::END;
			end
			default: begin
				state_nxt = spim_pkg::IDLE;  // END closes the burst
			end
		endcase
	end

	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			state    <= spim_pkg::IDLE;
			rdnwr_q  <= 1'b0;
			ssel_q   <= '0;
			word_cnt <= '0;
			rx_cnt   <= '0;
		end else begin
			state <= state_nxt;
			if ((state == spim_pkg::IDLE) && bus.cmd_valid) begin
				rdnwr_q  <= bus.cmd_rdnwr;
				ssel_q   <= bus.cmd_ssel;
				word_cnt <= bus.cmd_brstlen;
			end else if ((state == spim_pkg::SHIFT) && word_end) begin
				word_cnt <= word_cnt - 1'b1;
			end
			rx_cnt <= shifting ? rx_cnt + 1'b1 : '0;  // wraps every 32 bits
		end
	end

	assign bus.done = (state == spim_pkg::END);

	// first word at LOAD, later ones at bit 28 of the word before
	assign bus.tx_req = !rdnwr_q && ((state == spim_pkg::LOAD) ||
		((state == spim_pkg::SHIFT) && (rx_cnt == 5'd28)));

	////////////////////
	// receive side, rising edge
	////////////////////

	always_ff @(posedge sclk_in) begin
		if (shifting)
			rx_shift <= {rx_shift[30:0], miso};
		if (bus.tx_req)
			tx_hold <= bus.tx_data;
		if (word_end && rdnwr_q)
			bus.rx_data <= {rx_shift[30:0], miso};  // last bit comes straight from miso
	end

	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n)
			bus.rx_valid <= 1'b0;
		else
			bus.rx_valid <= word_end && rdnwr_q;
	end

	////////////////////
	// transmit side, falling edge
	////////////////////

	always_ff @(negedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			tx_cnt <= '0;
			mosi   <= 1'b0;
			ss_n   <= 4'hf;
		end else if (shifting) begin
			tx_cnt <= tx_cnt + 1'b1;
			mosi   <= (tx_cnt == '0) ? tx_load_word[31] : tx_shift[31];
			ss_n   <= ~(4'b0001 << ssel_q);  // only the selected slave goes low
		end else begin
			tx_cnt <= '0;
			mosi   <= 1'b0;
			ss_n   <= 4'hf;
		end
	end

	always_ff @(negedge sclk_in) begin
		if (shifting) begin
			if (tx_cnt == '0)
				tx_shift <= {tx_load_word[30:0], 1'b0};
			else
				tx_shift <= {tx_shift[30:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* hw/spim_rx_collect.sv */
/*
 * spim_rx_collect
 * holds one received word per lane and drains them round-robin into a single
 * credited output stream, flagging words lost to a full holding register
 */

`default_nettype none

module spim_rx_collect #(
	parameter  int NUM_LANES  = 2,
	parameter  int RX_CREDITS = 4,
	localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic              sclk_in,
	input  logic              rst_n,
	spim_lane_if.coll         lanes [NUM_LANES],
	output logic              rx_valid,
	output logic [LANE_W-1:0] rx_lane,
	output spim_pkg::word_t   rx_data,
	input  logic              rx_credit,
	output logic              rx_overflow
);

	localparam int CRD_W = $clog2(RX_CREDITS + 1);

	logic [NUM_LANES-1:0] lane_valid;
	logic [NUM_LANES-1:0] hold_valid;
	logic [NUM_LANES-1:0] hold_free;
	logic [NUM_LANES-1:0] drop;
	spim_pkg::word_t      lane_data [NUM_LANES];
	spim_pkg::word_t      hold_data [NUM_LANES];
	logic [LANE_W-1:0]    rr_ptr;
	logic [LANE_W-1:0]    gnt_idx;
	logic                 gnt_found;
	logic                 issue;
	logic [CRD_W-1:0]     credit_cnt;

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_in
		assign lane_valid[g] = lanes[g].rx_valid;
		assign lane_data[g]  = lanes[g].rx_data;
	end

	// first held word at or after the round-robin pointer
	always_comb begin
		int idx;
		gnt_found = 1'b0;
		gnt_idx   = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			idx = int'(rr_ptr) + k;
			if (idx >= NUM_LANES)
				idx = idx - NUM_LANES;
			if (!gnt_found && hold_valid[idx]) begin
				gnt_found = 1'b1;
				gnt_idx   = LANE_W'(idx);
			end
		end
	end

	assign issue = gnt_found && (credit_cnt != '0);

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			hold_free[i] = !hold_valid[i] || (issue && (gnt_idx == LANE_W'(i)));
			drop[i]      = lane_valid[i] && !hold_free[i];  // lane cannot stall
		end
	end

	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			hold_valid  <= '0;
			rr_ptr      <= '0;
			credit_cnt  <= CRD_W'(RX_CREDITS);
			rx_valid    <= 1'b0;
			rx_overflow <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_LANES; i++) begin
				if (lane_valid[i] && hold_free[i])
					hold_valid[i] <= 1'b1;
				else if (issue && (gnt_idx == LANE_W'(i)))
					hold_valid[i] <= 1'b0;
			end
			if (issue)
				rr_ptr <= (gnt_idx == LANE_W'(NUM_LANES - 1)) ? '0 : gnt_idx + 1'b1;
			case ({rx_credit, issue})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			rx_valid    <= issue;
			rx_overflow <= rx_overflow | (|drop);  // sticky until reset
		end
	end

	always_ff @(posedge sclk_in) begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (lane_valid[i] && hold_free[i])
				hold_data[i] <= lane_data[i];
		end
		if (issue) begin
			rx_lane <= gnt_idx;
			rx_data <= hold_data[gnt_idx];
		end
	end

endmodule

`default_nettype wire

/* hw/spim_subsys.sv */
/*
 * spim_subsys
 * multi-lane SPI master: command dispatcher, NUM_LANES burst engines and
 * the receive collector, with sclk_in forwarded as the SPI clock
 */

`default_nettype none

module spim_subsys #(
	parameter  int NUM_LANES  = 2,
	parameter  int TX_DEPTH   = 2,
	parameter  int RX_CREDITS = 4,
	localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                   sclk_in,
	input  logic                   rst_n,
	input  logic                   cmd_valid,
	input  logic                   cmd_rdnwr,
	input  logic [LANE_W-1:0]      cmd_lane,
	input  spim_pkg::ssel_t        cmd_ssel,
	input  spim_pkg::brstlen_t     cmd_brstlen,
	output logic [NUM_LANES-1:0]   cmd_credit,
	input  logic                   tx_valid,
	input  logic [LANE_W-1:0]      tx_lane,
	input  spim_pkg::word_t        tx_data,
	output logic [NUM_LANES-1:0]   tx_credit,
	output logic                   rx_valid,
	output logic [LANE_W-1:0]      rx_lane,
	output spim_pkg::word_t        rx_data,
	input  logic                   rx_credit,
	output logic                   rx_overflow,
	output logic                   sclk,
	output logic [4*NUM_LANES-1:0] ss_n,
	output logic [NUM_LANES-1:0]   mosi,
	input  logic [NUM_LANES-1:0]   miso
);

	spim_lane_if lane_bus [NUM_LANES] ();

	assign sclk = sclk_in;  // mode 0, clock forwarded as is

	spim_dispatch #(
		.NUM_LANES (NUM_LANES),
		.TX_DEPTH  (TX_DEPTH)
	) i_dispatch (
		.sclk_in     (sclk_in),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_rdnwr   (cmd_rdnwr),
		.cmd_lane    (cmd_lane),
		.cmd_ssel    (cmd_ssel),
		.cmd_brstlen (cmd_brstlen),
		.tx_valid    (tx_valid),
		.tx_lane     (tx_lane),
		.tx_data     (tx_data),
		.cmd_credit  (cmd_credit),
		.tx_credit   (tx_credit),
		.lanes       (lane_bus)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		spim_lane i_lane (
			.sclk_in (sclk_in),
			.rst_n   (rst_n),
			.ss_n    (ss_n[4*g +: 4]),
			.mosi    (mosi[g]),
			.miso    (miso[g]),
			.bus     (lane_bus[g])
		);
	end

	spim_rx_collect #(
		.NUM_LANES  (NUM_LANES),
		.RX_CREDITS (RX_CREDITS)
	) i_rx_collect (
		.sclk_in     (sclk_in),
		.rst_n       (rst_n),
		.lanes       (lane_bus),
		.rx_valid    (rx_valid),
		.rx_lane     (rx_lane),
		.rx_data     (rx_data),
		.rx_credit   (rx_credit),
		.rx_overflow (rx_overflow)
	);

endmodule

`default_nettype wire

/* verification/spim_lane_checker.sv */
/*
 * spim_lane_checker
 * assertions on one SPI lane: slave select exclusivity, idle select state
 * and quiet MOSI on reads
 */

`default_nettype none

module spim_lane_checker (
	input logic               sclk_in,
	input logic               rst_n,
	input logic [3:0]         ss_n,
	input logic               mosi,
	input spim_pkg::lane_st_e state,
	input logic               rdnwr_q
);

	a_one_select: assert property (@(posedge sclk_in) disable iff (!rst_n)
		$countones(~ss_n) <= 1)
		else $error("more than one slave select low");

	a_idle_deselect: assert property (@(posedge sclk_in) disable iff (!rst_n)
		(state == spim_pkg::IDLE) |-> (ss_n == 4'hf))
		else $error("slave select low while the lane is idle");

	a_read_quiet: assert property (@(posedge sclk_in) disable iff (!rst_n)
		rdnwr_q |-> !mosi)
		else $error("mosi high during a read");

endmodule

bind spim_lane spim_lane_checker i_checker (
	.sclk_in (sclk_in),
	.rst_n   (rst_n),
	.ss_n    (ss_n),
	.mosi    (mosi),
	.state   (state),
	.rdnwr_q (rdnwr_q)
);

`default_nettype wire

/* verification/spim_tb.sv */
/*
 * spim_tb
 * random burst commands on two lanes against slave models and a reference
 * model of the credit, transmit and receive paths, then a receive overflow case
 */

`default_nettype none

module spim_tb;

	localparam int NUM_LANES  = 2;
	localparam int TX_DEPTH   = 2;
	localparam int RX_CREDITS = 4;
	localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int CLK_PERIOD = 40;
	localparam int NUM_CMDS   = 40;
	localparam int WD_CYCLES  = NUM_CMDS * 4 * 32 * 2 + 2000;  // overflow case fits the margin

	logic                   sclk_in;
	logic                   rst_n;
	logic                   cmd_valid;
	logic                   cmd_rdnwr;
	logic [LANE_W-1:0]      cmd_lane;
	spim_pkg::ssel_t        cmd_ssel;
	spim_pkg::brstlen_t     cmd_brstlen;
	logic [NUM_LANES-1:0]   cmd_credit;
	logic                   tx_valid;
	logic [LANE_W-1:0]      tx_lane;
	spim_pkg::word_t        tx_data;
	logic [NUM_LANES-1:0]   tx_credit;
	logic                   rx_valid;
	logic [LANE_W-1:0]      rx_lane;
	spim_pkg::word_t        rx_data;
	logic                   rx_credit;
	logic                   rx_overflow;
	logic                   sclk;
	logic [4*NUM_LANES-1:0] ss_n;
	logic [NUM_LANES-1:0]   mosi;
	logic [NUM_LANES-1:0]   miso;

	// reference model state, per lane
	int                 cmd_crd    [NUM_LANES];
	int                 tx_crd     [NUM_LANES];
	bit                 busy       [NUM_LANES];
	logic               cur_rd     [NUM_LANES];
	spim_pkg::ssel_t    cur_sel    [NUM_LANES];
	spim_pkg::brstlen_t cur_len    [NUM_LANES];
	int                 words_seen [NUM_LANES];
	int                 tx_pulses  [NUM_LANES];
	spim_pkg::word_t    exp_tx     [NUM_LANES][$];  // words pushed, not yet seen on mosi
	spim_pkg::word_t    exp_rx     [NUM_LANES][$];  // miso words of reads, not yet at rx_data
	spim_pkg::word_t    cap        [NUM_LANES];
	int                 cap_bits   [NUM_LANES];
	spim_pkg::word_t    miso_word  [NUM_LANES];
	int                 miso_bits  [NUM_LANES];
	int                 owed;        // rx credits to hand back
	bit                 hold_credit;
	bit                 feed_en;
	int                 feed_ptr;
	int                 exp_lane;    // -1 when any lane may deliver
	int                 errors;

	spim_subsys #(
		.NUM_LANES  (NUM_LANES),
		.TX_DEPTH   (TX_DEPTH),
		.RX_CREDITS (RX_CREDITS)
	) i_dut (
		.sclk_in     (sclk_in),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_rdnwr   (cmd_rdnwr),
		.cmd_lane    (cmd_lane),
		.cmd_ssel    (cmd_ssel),
		.cmd_brstlen (cmd_brstlen),
		.cmd_credit  (cmd_credit),
		.tx_valid    (tx_valid),
		.tx_lane     (tx_lane),
		.tx_data     (tx_data),
		.tx_credit   (tx_credit),
		.rx_valid    (rx_valid),
		.rx_lane     (rx_lane),
		.rx_data     (rx_data),
		.rx_credit   (rx_credit),
		.rx_overflow (rx_overflow),
		.sclk        (sclk),
		.ss_n        (ss_n),
		.mosi        (mosi),
		.miso        (miso)
	);

	initial begin
		sclk_in = 1'b0;
		forever #(CLK_PERIOD / 2) sclk_in = ~sclk_in;
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic fail_run(input string msg);
		errors++;
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input spim_pkg::word_t got,
			input spim_pkg::word_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	task automatic check_lane(input string name, input logic [LANE_W-1:0] got,
			input logic [LANE_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_sel(input string name, input spim_pkg::ssel_t got,
			input spim_pkg::ssel_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// index of the single low bit in a select group
	function automatic spim_pkg::ssel_t low_select(input logic [3:0] grp);
		spim_pkg::ssel_t idx;
		idx = '0;
		for (int b = 0; b < 4; b++)
			if (!grp[b])
				idx = spim_pkg::ssel_t'(b);
		return idx;
	endfunction

	function automatic bit any_busy();
		bit res;
		res = 1'b0;
		for (int l = 0; l < NUM_LANES; l++)
			res = res | busy[l];
		return res;
	endfunction

	function automatic bit rx_pending();
		bit res;
		res = 1'b0;
		for (int l = 0; l < NUM_LANES; l++)
			res = res | (exp_rx[l].size() != 0);
		return res;
	endfunction

	// forwarded spi clock follows sclk_in
	always @(posedge sclk_in) begin
		#1;
		check_flag("sclk", sclk, 1'b1);
	end

	////////////////////
	// slave models, one per lane, select checked against the command
	////////////////////

	always @(posedge sclk) begin
		logic [3:0] grp;
		for (int l = 0; l < NUM_LANES; l++) begin
			grp = ss_n[4*l +: 4];
			if (rst_n && (grp != 4'hf)) begin
				if (!busy[l])
					fail_run($sformatf("ss_n low on lane %0d with no command", l));
				if ($countones(~grp) != 1)
					fail_run($sformatf("more than one ss_n low on lane %0d", l));
				check_sel("ss_n select", low_select(grp), cur_sel[l]);
				cap[l] = {cap[l][30:0], mosi[l]};
				cap_bits[l]++;
				if (cap_bits[l] == 32) begin
					cap_bits[l] = 0;
					words_seen[l]++;
					if (cur_rd[l])
						check_word("mosi on read", cap[l], '0);
					else if (exp_tx[l].size() == 0)
						fail_run($sformatf("write word on lane %0d with none queued", l));
					else
						check_word("mosi on write", cap[l], exp_tx[l].pop_front());
				end
			end
		end
	end

	// miso changes just after the falling edge, once ss_n has settled
	always @(negedge sclk) begin
		#1;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (rst_n && (ss_n[4*l +: 4] != 4'hf)) begin
				if (miso_bits[l] == 0) begin
					miso_word[l] = $urandom;
					if (cur_rd[l])
						exp_rx[l].push_back(miso_word[l]);
				end
				miso[l]      = miso_word[l][31 - miso_bits[l]];
				miso_bits[l] = (miso_bits[l] + 1) % 32;
			end else begin
				miso[l]      = 1'b0;
				miso_bits[l] = 0;
			end
		end
	end

	////////////////////
	// credits, transmit feed and receive stream
	////////////////////

	always @(negedge sclk_in) begin
		int  l;
		bit  pushed;
		if (rst_n) begin
			for (int k = 0; k < NUM_LANES; k++) begin
				if (cmd_credit[k]) begin
					if (cmd_crd[k] != 0)
						fail_run($sformatf("cmd_credit on lane %0d with no command", k));
					check_count("words per command", words_seen[k], int'(cur_len[k]) + 1);
					check_count("tx_credit pulses per command", tx_pulses[k],
						cur_rd[k] ? 0 : int'(cur_len[k]) + 1);
					check_flag("ss_n high after command", &ss_n[4*k +: 4], 1'b1);
					words_seen[k] = 0;
					tx_pulses[k]  = 0;
					busy[k]       = 1'b0;
					cmd_crd[k]    = 1;
				end
				if (tx_credit[k]) begin
					tx_crd[k]++;
					tx_pulses[k]++;
					if (tx_crd[k] > TX_DEPTH)
						fail_run($sformatf("tx_credit on lane %0d with an empty buffer", k));
				end
			end
			tx_valid = 1'b0;
			pushed   = 1'b0;
			for (int k = 0; k < NUM_LANES; k++) begin
				l = (feed_ptr + k) % NUM_LANES;
				if (feed_en && !pushed && (tx_crd[l] > 0)) begin
					tx_valid = 1'b1;
					tx_lane  = LANE_W'(l);
					tx_data  = $urandom;
					exp_tx[l].push_back(tx_data);
					tx_crd[l]--;
					feed_ptr = (l + 1) % NUM_LANES;
					pushed   = 1'b1;
				end
			end
			if (rx_valid) begin
				if (exp_lane >= 0)
					check_lane("rx_lane", rx_lane, exp_lane[LANE_W-1:0]);
				if (exp_rx[rx_lane].size() == 0)
					fail_run($sformatf("rx_valid on lane %0d with no read word", rx_lane));
				else
					check_word("rx_data", rx_data, exp_rx[rx_lane].pop_front());
				owed++;
			end
			rx_credit = 1'b0;
			if (!hold_credit && (owed > 0)) begin
				rx_credit = 1'b1;
				owed--;
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic issue_cmd(input int lane, input logic rd, input spim_pkg::ssel_t sel,
			input spim_pkg::brstlen_t len);
		@(posedge sclk_in);
		while (cmd_crd[lane] == 0)
			@(posedge sclk_in);
		@(negedge sclk_in);
		cmd_crd[lane]--;
		busy[lane]    = 1'b1;
		cur_rd[lane]  = rd;
		cur_sel[lane] = sel;
		cur_len[lane] = len;
		cmd_valid     = 1'b1;
		cmd_lane      = LANE_W'(lane);
		cmd_rdnwr     = rd;
		cmd_ssel      = sel;
		cmd_brstlen   = len;
		@(negedge sclk_in);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle(input bit with_rx);
		@(posedge sclk_in);
		while (any_busy() || (with_rx && rx_pending()))
			@(posedge sclk_in);
	endtask

	task automatic check_quiet();
		check_flag("ss_n all high", &ss_n, 1'b1);
		check_flag("mosi", |mosi, 1'b0);
		check_flag("cmd_credit", |cmd_credit, 1'b0);
		check_flag("tx_credit", |tx_credit, 1'b0);
		check_flag("rx_valid", rx_valid, 1'b0);
		check_flag("rx_overflow", rx_overflow, 1'b0);
	endtask

	initial begin
		int                 lane;
		logic               rd;
		spim_pkg::ssel_t    sel;
		spim_pkg::brstlen_t len;
		rst_n       = 1'b0;
		cmd_valid   = 1'b0;
		cmd_rdnwr   = 1'b0;
		cmd_lane    = '0;
		cmd_ssel    = '0;
		cmd_brstlen = '0;
		tx_valid    = 1'b0;
		tx_lane     = '0;
		tx_data     = '0;
		rx_credit   = 1'b0;
		miso        = '0;
		owed        = 0;
		hold_credit = 1'b0;
		feed_en     = 1'b0;
		feed_ptr    = 0;
		exp_lane    = -1;
		errors      = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			cmd_crd[l]    = 1;
			tx_crd[l]     = TX_DEPTH;
			busy[l]       = 1'b0;
			cur_rd[l]     = 1'b0;
			cur_sel[l]    = '0;
			cur_len[l]    = '0;
			words_seen[l] = 0;
			tx_pulses[l]  = 0;
			cap[l]        = '0;
			cap_bits[l]   = 0;
			miso_bits[l]  = 0;
		end
		void'($urandom(32'h9aa3_e144));
		repeat (8) @(posedge sclk_in);
		@(negedge sclk_in);
		rst_n = 1'b1;
		repeat (4) begin
			@(negedge sclk_in);
			check_quiet();
		end
		feed_en = 1'b1;
		repeat (8) @(negedge sclk_in);  // buffers fill up

		for (int n = 0; n < NUM_CMDS; n++) begin
			@(posedge sclk_in);
			lane = $urandom % NUM_LANES;
			rd   = $urandom % 2;
			sel  = spim_pkg::ssel_t'($urandom % 4);
			len  = spim_pkg::brstlen_t'($urandom % 4);
			issue_cmd(lane, rd, sel, len);
		end
		wait_idle(1'b1);
		check_flag("rx_overflow after random commands", rx_overflow, 1'b0);

		// spend all rx credits, then a second read overruns the holding register
		hold_credit = 1'b1;
		exp_lane    = 0;
		issue_cmd(0, 1'b1, spim_pkg::ssel_t'($urandom % 4), 14'd3);
		wait_idle(1'b1);
		check_flag("rx_overflow with credits spent", rx_overflow, 1'b0);
		issue_cmd(0, 1'b1, spim_pkg::ssel_t'($urandom % 4), 14'd3);
		wait_idle(1'b0);
		check_flag("rx_overflow after dropped words", rx_overflow, 1'b1);
		while (exp_rx[0].size() > 1)
			void'(exp_rx[0].pop_back());  // only the first word is held
		hold_credit = 1'b0;
		wait_idle(1'b1);
		repeat (20) @(negedge sclk_in);
		check_flag("rx_overflow stays set", rx_overflow, 1'b1);

		for (int l = 0; l < NUM_LANES; l++)
			check_count("words left in tx buffer", exp_tx[l].size(), TX_DEPTH - tx_crd[l]);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		fail_run($sformatf("timeout, run did not finish within %0d cycles", WD_CYCLES));
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/spim_pkg.sv
hw/spim_lane_if.sv
hw/spim_dispatch.sv
hw/spim_lane.sv
hw/spim_rx_collect.sv
hw/spim_subsys.sv
verification/spim_lane_checker.sv
verification/spim_tb.sv

/* Bender.yml */
package:
  name: spim_subsys

sources:
  - files:
      - hw/spim_pkg.sv
      - hw/spim_lane_if.sv
      - hw/spim_dispatch.sv
      - hw/spim_lane.sv
      - hw/spim_rx_collect.sv
      - hw/spim_subsys.sv
  - target: test
    files:
      - verification/spim_lane_checker.sv
      - verification/spim_tb.sv
